// File: rtl/ebusPkg.sv
package ebusPkg;

  // One EBUS data word
  typedef logic [35:0] ebusWord;

  // Device number on the bus, the top value addresses every device at once
  typedef logic [2:0] devIndex;

  // Register number inside one device
  typedef logic [1:0] regIndex;

  // APB byte address: device in bits 6 to 4, register in bits 3 to 2
  typedef logic [6:0] apbAdr;

  localparam devIndex broadcastDev = 3'd7;

  // The last register slot of a device returns its write counter
  localparam regIndex counterReg = 2'd3;

  typedef enum logic [1:0] {
    idle,
    access,
    readWait
  } bridgeState;

endpackage

// File: rtl/ebusApbBridge.sv
`timescale 1ns/1ns

module ebusApbBridge #(
  parameter int numDevices = 4
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  ebusPkg::apbAdr   paddr,
  input  ebusPkg::ebusWord pwdata,
  input  ebusPkg::ebusWord ebusData,
  output ebusPkg::ebusWord prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             wrStrobe,
  output logic             rdStrobe,
  output ebusPkg::devIndex devSel,
  output ebusPkg::regIndex regSel,
  output ebusPkg::ebusWord wrData
);

  ebusPkg::bridgeState state;
  ebusPkg::bridgeState nextState;
  logic badDevice;
  logic accessCycle;

  // The master holds paddr and pwdata for the whole transfer, so the
  // selects can be taken straight from the bus
  assign devSel = paddr[6:4];
  assign regSel = paddr[3:2];
  assign wrData = pwdata;

  // Broadcast is always legal, any other number must name a real device
  assign badDevice = (devSel != ebusPkg::broadcastDev) && (int'(devSel) >= numDevices);

  // First access cycle of a transfer
  assign accessCycle = (state == ebusPkg::access) && psel && penable;

  always_comb begin
    nextState = state;
    case (state)
      ebusPkg::idle: begin
        // Only a setup phase starts a transfer, a stray penable is ignored
        if (psel && !penable) begin
          nextState = ebusPkg::access;
        end
      end
      ebusPkg::access: begin
        if (accessCycle && !pwrite && !badDevice) begin
          nextState = ebusPkg::readWait;
        end else begin
          nextState = ebusPkg::idle;
        end
      end
      ebusPkg::readWait: begin
        nextState = ebusPkg::idle;
      end
      default: begin
        nextState = ebusPkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ebusPkg::idle;
    end else begin
      state <= nextState;
    end
  end

  // Writes and errors finish in the first access cycle
  // Reads need one more cycle while the mux registers the bus
  assign pready = (accessCycle && (pwrite || badDevice)) || (state == ebusPkg::readWait);

  assign pslverr = accessCycle && badDevice;

  // Strobes last exactly one cycle since access is left at the next edge
  assign wrStrobe = accessCycle && pwrite && !badDevice;
  assign rdStrobe = accessCycle && !pwrite && !badDevice;

  // The registered bus word is only returned while a read completes
  assign prdata = (state == ebusPkg::readWait) ? ebusData : '0;

endmodule

// File: rtl/ebusDevice.sv
`timescale 1ns/1ns

module ebusDevice #(
  parameter int devId = 0
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             wrStrobe,
  input  logic             rdStrobe,
  input  ebusPkg::devIndex devSel,
  input  ebusPkg::regIndex regSel,
  input  ebusPkg::ebusWord wrData,
  output logic             driving,
  output ebusPkg::ebusWord driveData
);

  ebusPkg::ebusWord genReg [0:2];
  ebusPkg::ebusWord writeCount;
  ebusPkg::ebusWord readWord;
  logic selected;

  // Respond to our own number and to broadcast
  assign selected = (int'(devSel) == devId) || (devSel == ebusPkg::broadcastDev);

  // Writes to the counter slot are dropped and not counted
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      genReg[0] <= '0;
      genReg[1] <= '0;
      genReg[2] <= '0;
      writeCount <= '0;
    end else if (wrStrobe && selected && (regSel != ebusPkg::counterReg)) begin
      genReg[regSel] <= wrData;
      // Counter wraps at 2^36
      writeCount <= writeCount + 1'b1;
    end
  end

  always_comb begin
    case (regSel)
      2'd0: begin
        readWord = genReg[0];
      end
      2'd1: begin
        readWord = genReg[1];
      end
      2'd2: begin
        readWord = genReg[2];
      end
      default: begin
        readWord = writeCount;
      end
    endcase
  end

  // Bus driver, active only for the single read strobe cycle
  assign driving = rdStrobe && selected;
  assign driveData = driving ? readWord : '0;

endmodule

// File: rtl/ebusMux.sv
`timescale 1ns/1ns

module ebusMux #(
  parameter int numDevices = 4
) (
  input  logic                               clk,
  input  logic                               arstN,
  input  logic             [numDevices-1:0] driving,
  input  ebusPkg::ebusWord [numDevices-1:0] driveData,
  output ebusPkg::ebusWord                   ebusData,
  output logic                               ebusConflict
);

  ebusPkg::ebusWord busWord;
  logic [3:0] driverCount;

  // Walk from the top down so the lowest driving index is the last to win
  always_comb begin
    busWord = '0;
    for (int i = numDevices - 1; i >= 0; i--) begin
      if (driving[i]) begin
        busWord = driveData[i];
      end
    end
  end

  always_comb begin
    driverCount = '0;
    for (int i = 0; i < numDevices; i++) begin
      driverCount = driverCount + 4'(driving[i]);
    end
  end

  always_ff @(posedge clk) begin
    ebusData <= busWord;
  end

  // Sticky until reset, the host reads it as a history bit
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ebusConflict <= 1'b0;
    end else if (driverCount > 4'd1) begin
      ebusConflict <= 1'b1;
    end
  end

endmodule

// File: rtl/ebusTop.sv
`timescale 1ns/1ns

module ebusTop #(
  parameter int numDevices = 4
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  ebusPkg::apbAdr   paddr,
  input  ebusPkg::ebusWord pwdata,
  output ebusPkg::ebusWord prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             ebusConflict
);

  logic wrStrobe;
  logic rdStrobe;
  ebusPkg::devIndex devSel;
  ebusPkg::regIndex regSel;
  ebusPkg::ebusWord wrData;
  ebusPkg::ebusWord ebusData;

  // Per device bus drivers, gathered by the mux
  logic [numDevices-1:0] driving;
  ebusPkg::ebusWord [numDevices-1:0] driveData;

  ebusApbBridge #(
    .numDevices(numDevices)
  ) ebusApbBridge_inst (
    .clk      (clk),
    .arstN    (arstN),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .ebusData (ebusData),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .wrStrobe (wrStrobe),
    .rdStrobe (rdStrobe),
    .devSel   (devSel),
    .regSel   (regSel),
    .wrData   (wrData)
  );

  for (genvar i = 0; i < numDevices; i++) begin : gDev
    ebusDevice #(
      .devId(i)
    ) ebusDevice_inst (
      .clk       (clk),
      .arstN     (arstN),
      .wrStrobe  (wrStrobe),
      .rdStrobe  (rdStrobe),
      .devSel    (devSel),
      .regSel    (regSel),
      .wrData    (wrData),
      .driving   (driving[i]),
      .driveData (driveData[i])
    );
  end

  ebusMux #(
    .numDevices(numDevices)
  ) ebusMux_inst (
    .clk          (clk),
    .arstN        (arstN),
    .driving      (driving),
    .driveData    (driveData),
    .ebusData     (ebusData),
    .ebusConflict (ebusConflict)
  );

endmodule

// File: bench/ebusTop_assert.sv
`timescale 1ns/1ns

module ebusTopAssert (
  input logic           clk,
  input logic           arstN,
  input logic           psel,
  input logic           penable,
  input logic           pwrite,
  input ebusPkg::apbAdr paddr,
  input logic           pready,
  input logic           pslverr,
  input logic           wrStrobe,
  input logic           rdStrobe
);

  // Number of assertion failures seen so far
  int failCount = 0;

  // Address and direction hold from the setup cycle until the transfer completes
  addrStable: assert property (@(posedge clk) disable iff (!arstN)
    (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite)))
    else begin
      failCount = failCount + 1;
      $error("paddr or pwrite changed while a transfer was pending");
    end

  strobeExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(rdStrobe && wrStrobe))
    else begin
      failCount = failCount + 1;
      $error("rdStrobe and wrStrobe were high in the same cycle");
    end

  // No wait states are added after completion, so pready is a single pulse
  readyPulse: assert property (@(posedge clk) disable iff (!arstN)
    pready |=> !pready)
    else begin
      failCount = failCount + 1;
      $error("pready stayed high for more than one cycle");
    end

  errorWithReady: assert property (@(posedge clk) disable iff (!arstN)
    pslverr |-> pready)
    else begin
      failCount = failCount + 1;
      $error("pslverr was high without pready");
    end

endmodule

bind ebusTop ebusTopAssert ebusTopAssert_inst (
  .clk      (clk),
  .arstN    (arstN),
  .psel     (psel),
  .penable  (penable),
  .pwrite   (pwrite),
  .paddr    (paddr),
  .pready   (pready),
  .pslverr  (pslverr),
  .wrStrobe (wrStrobe),
  .rdStrobe (rdStrobe)
);

// File: bench/ebusTb.sv
`timescale 1ns/1ns

module ebusTb;

  localparam int numDevices = 4;
  localparam int numRandom = 300;
  // Reset reads, one broadcast write, eight reads after it, one write to device 0
  // and one broadcast read
  localparam int numDirected = 27;
  // A transfer takes at most three cycles: setup, access and the read wait state
  localparam int maxCycles = (numRandom + numDirected) * 3 + 100;

  logic clk;
  logic arstN;
  logic psel;
  logic penable;
  logic pwrite;
  ebusPkg::apbAdr paddr;
  ebusPkg::ebusWord pwdata;
  ebusPkg::ebusWord prdata;
  logic pready;
  logic pslverr;
  logic ebusConflict;

  logic [31:0] lfsrState;
  int cycleCount;

  // Register model: three general registers and a write counter per device
  ebusPkg::ebusWord modelReg [0:numDevices-1][0:2];
  ebusPkg::ebusWord modelCount [0:numDevices-1];
  logic modelConflict;

  ebusTop #(
    .numDevices(numDevices)
  ) ebusTop_inst (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      failRun($sformatf("Timeout after %0d cycles before all transfers finished", cycleCount));
    end
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [35:0] randomBits(input int count);
    logic [35:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
      value = {value[34:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic ebusPkg::ebusWord modelRead(input int dev, input ebusPkg::regIndex regNum);
    if (regNum == ebusPkg::counterReg) begin
      return modelCount[dev];
    end
    return modelReg[dev][regNum];
  endfunction

  function automatic void modelWrite(input int dev, input ebusPkg::regIndex regNum,
                                     input ebusPkg::ebusWord data);
    if (regNum != ebusPkg::counterReg) begin
      modelReg[dev][regNum] = data;
      modelCount[dev] = modelCount[dev] + 1'b1;
    end
  endfunction

  // One APB transfer; waits counts the access cycles that had pready low
  task automatic apbTransfer(input logic write, input ebusPkg::apbAdr addr,
                             input ebusPkg::ebusWord data, output ebusPkg::ebusWord rdata,
                             output logic err, output int waits);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err = pslverr;
  endtask

  task automatic checkedTransfer(input logic write, input ebusPkg::devIndex dev,
                                 input ebusPkg::regIndex regNum, input ebusPkg::ebusWord data);
    ebusPkg::ebusWord expData;
    ebusPkg::ebusWord rdata;
    logic expErr;
    logic err;
    int expWait;
    int waits;
    // Device numbers from numDevices up to 6 name no device
    expErr = (int'(dev) >= numDevices) && (int'(dev) <= 6);
    expData = '0;
    expWait = (write || expErr) ? 0 : 1;
    if (!expErr && (dev == ebusPkg::broadcastDev)) begin
      if (write) begin
        for (int d = 0; d < numDevices; d++) begin
          modelWrite(d, regNum, data);
        end
      end else begin
        // Every device drives, the lowest index wins the bus
        expData = modelRead(0, regNum);
        modelConflict = modelConflict || (numDevices > 1);
      end
    end else if (!expErr) begin
      if (write) begin
        modelWrite(int'(dev), regNum, data);
      end else begin
        expData = modelRead(int'(dev), regNum);
      end
    end
    apbTransfer(write, {dev, regNum, 2'b00}, data, rdata, err, waits);
    assert (err === expErr)
      else failRun($sformatf("MISMATCH pslverr expected %h got %h", expErr, err));
    if (!write || expErr) begin
      assert (rdata === expData)
        else failRun($sformatf("MISMATCH prdata expected %h got %h", expData, rdata));
    end
    assert (waits == expWait)
      else failRun($sformatf("MISMATCH pready wait cycles expected %h got %h", expWait, waits));
    assert (ebusConflict === modelConflict)
      else failRun($sformatf("MISMATCH ebusConflict expected %h got %h", modelConflict,
                             ebusConflict));
  endtask

  initial begin
    logic [35:0] bits;
    logic write;
    ebusPkg::devIndex dev;
    ebusPkg::regIndex regNum;
    clk = 1'b0;
    arstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    cycleCount = 0;
    lfsrState = 32'h4f30_a530;
    modelConflict = 1'b0;
    for (int d = 0; d < numDevices; d++) begin
      modelCount[d] = '0;
      for (int r = 0; r < 3; r++) begin
        modelReg[d][r] = '0;
      end
    end
    repeat (3) @(posedge clk);
    arstN <= 1'b1;

    // Every register and counter reads zero straight after reset
    for (int d = 0; d < numDevices; d++) begin
      for (int r = 0; r < 4; r++) begin
        checkedTransfer(1'b0, 3'(d), 2'(r), '0);
      end
    end

    // A broadcast write lands in every device and bumps every counter
    bits = randomBits(36);
    checkedTransfer(1'b1, ebusPkg::broadcastDev, 2'd1, bits);
    for (int d = 0; d < numDevices; d++) begin
      checkedTransfer(1'b0, 3'(d), 2'd1, '0);
      checkedTransfer(1'b0, 3'(d), ebusPkg::counterReg, '0);
    end

    // Device 0 now holds its own value, so the broadcast read shows which device wins
    bits = randomBits(36);
    checkedTransfer(1'b1, 3'd0, 2'd1, bits);
    checkedTransfer(1'b0, ebusPkg::broadcastDev, 2'd1, '0);

    for (int i = 0; i < numRandom; i++) begin
      bits = randomBits(1);
      write = bits[0];
      bits = randomBits(3);
      dev = bits[2:0];
      bits = randomBits(2);
      regNum = bits[1:0];
      bits = randomBits(36);
      checkedTransfer(write, dev, regNum, bits);
    end

    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    repeat (3) @(posedge clk);
    if (ebusTop_inst.ebusTopAssert_inst.failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("Concurrent assertions failed %0d times",
               ebusTop_inst.ebusTopAssert_inst.failCount);
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/ebusPkg.sv
rtl/ebusApbBridge.sv
rtl/ebusDevice.sv
rtl/ebusMux.sv
rtl/ebusTop.sv
bench/ebusTop_assert.sv
bench/ebusTb.sv
